/* rtl/branch_params.svh */
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Data path width
`define XLEN 32

// Major opcode shared by all 32-bit conditional branches
`define OPC_BRANCH 7'b1100011

// Branch kind codes, equal to the B-type funct3 field
`define BRA_BEQ  3'b000
`define BRA_BNE  3'b001
`define BRA_BLT  3'b100
`define BRA_BGE  3'b101
`define BRA_BLTU 3'b110
`define BRA_BGEU 3'b111

// Compressed branch fields, quadrant 1
`define C_OP_BRANCH 2'b01
`define C_F3_BEQZ   3'b110
`define C_F3_BNEZ   3'b111

`endif

/* rtl/branch_pkg.sv */
`default_nettype none

package branch_pkg;

    // Register operand as read for the branch
    typedef logic [31:0] word_t;

    // Program counter, immediate offset or target address
    typedef logic [31:0] addr_t;

    // Raw instruction word
    // A compressed instruction occupies bits 15:0
    typedef logic [31:0] instr_t;

    // Branch kind, coded like the B-type funct3
    typedef logic [2:0] br_kind_t;

endpackage

`default_nettype wire

/* rtl/branch_decode.sv */
`default_nettype none

`include "branch_params.svh"

module branch_decode (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 valid_i,
    input  branch_pkg::instr_t   instr_i,
    input  branch_pkg::addr_t    pc_i,
    input  branch_pkg::word_t    rs1_val_i,
    input  branch_pkg::word_t    rs2_val_i,
    input  logic                 pred_taken_i,
    output logic                 dec_valid_o,
    output branch_pkg::br_kind_t dec_kind_o,
    output branch_pkg::addr_t    dec_pc_o,
    output branch_pkg::addr_t    dec_imm_o,
    output logic                 dec_compressed_o,
    output logic                 dec_pred_o,
    output branch_pkg::word_t    dec_op_a_o,
    output branch_pkg::word_t    dec_op_b_o
);
    import branch_pkg::*;

    logic     is_comp;
    br_kind_t f3_full;
    logic [2:0] f3_comp;
    logic     f3_ok;
    logic     full_hit;
    logic     comp_hit;
    addr_t    b_imm;
    addr_t    cb_imm;
    br_kind_t kind_d;
    addr_t    imm_d;
    word_t    op_b_d;

    assign is_comp = (instr_i[1:0] != 2'b11); // Full words end in 11
    assign f3_full = instr_i[14:12];
    assign f3_comp = instr_i[15:13];

    // Funct3 values 010 and 011 are reserved for branches
    always_comb begin
        case (f3_full)
            `BRA_BEQ, `BRA_BNE, `BRA_BLT,
            `BRA_BGE, `BRA_BLTU, `BRA_BGEU: f3_ok = 1'b1;
            default:                        f3_ok = 1'b0;
        endcase
    end

    assign full_hit = !is_comp && (instr_i[6:0] == `OPC_BRANCH) && f3_ok;
    assign comp_hit = (instr_i[1:0] == `C_OP_BRANCH) &&
                      ((f3_comp == `C_F3_BEQZ) || (f3_comp == `C_F3_BNEZ));

    // B-type offset, bit 0 always zero
    assign b_imm  = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
    // CB-type offset[8|4:3] in 12:10, offset[7:6|2:1|5] in 6:2
    assign cb_imm = {{23{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
                     instr_i[11:10], instr_i[4:3], 1'b0};

    always_comb begin
        if (is_comp) begin
            kind_d = (f3_comp == `C_F3_BNEZ) ? `BRA_BNE : `BRA_BEQ;
            imm_d  = cb_imm;
            op_b_d = {`XLEN{1'b0}}; // Compare rs1' against zero
        end else begin
            kind_d = f3_full;
            imm_d  = b_imm;
            op_b_d = rs2_val_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            dec_valid_o <= 1'b0;
        end else if (!stall_i) begin
            dec_valid_o <= valid_i && (full_hit || comp_hit); // Others dropped here
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_kind_o       <= kind_d;
            dec_pc_o         <= pc_i;
            dec_imm_o        <= imm_d;
            dec_compressed_o <= is_comp;
            dec_pred_o       <= pred_taken_i;
            dec_op_a_o       <= rs1_val_i;
            dec_op_b_o       <= op_b_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_compare.sv */
`default_nettype none

module branch_compare (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 dec_valid_i,
    input  branch_pkg::br_kind_t dec_kind_i,
    input  branch_pkg::addr_t    dec_pc_i,
    input  branch_pkg::addr_t    dec_imm_i,
    input  logic                 dec_compressed_i,
    input  logic                 dec_pred_i,
    input  branch_pkg::word_t    dec_op_a_i,
    input  branch_pkg::word_t    dec_op_b_i,
    output logic                 cmp_valid_o,
    output branch_pkg::br_kind_t cmp_kind_o,
    output branch_pkg::addr_t    cmp_pc_o,
    output branch_pkg::addr_t    cmp_imm_o,
    output logic                 cmp_compressed_o,
    output logic                 cmp_pred_o,
    output logic                 cmp_eq_o,
    output logic                 cmp_gt_s_o,
    output logic                 cmp_gt_u_o
);

    logic eq_d;
    logic gt_u_d;
    logic gt_s_d;
    logic sign_diff;

    assign eq_d      = (dec_op_a_i == dec_op_b_i);
    assign gt_u_d    = (dec_op_a_i > dec_op_b_i);
    assign sign_diff = dec_op_a_i[31] ^ dec_op_b_i[31];

    // Signed result reuses the unsigned compare unless the signs differ
    assign gt_s_d = sign_diff ? dec_op_b_i[31] : gt_u_d;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cmp_valid_o <= 1'b0;
        end else if (!stall_i) begin
            cmp_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            cmp_kind_o       <= dec_kind_i;
            cmp_pc_o         <= dec_pc_i;
            cmp_imm_o        <= dec_imm_i;
            cmp_compressed_o <= dec_compressed_i;
            cmp_pred_o       <= dec_pred_i;
            cmp_eq_o         <= eq_d;
            cmp_gt_s_o       <= gt_s_d;
            cmp_gt_u_o       <= gt_u_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_resolve.sv */
`default_nettype none

`include "branch_params.svh"

module branch_resolve (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 cmp_valid_i,
    input  branch_pkg::br_kind_t cmp_kind_i,
    input  branch_pkg::addr_t    cmp_pc_i,
    input  branch_pkg::addr_t    cmp_imm_i,
    input  logic                 cmp_compressed_i,
    input  logic                 cmp_pred_i,
    input  logic                 cmp_eq_i,
    input  logic                 cmp_gt_s_i,
    input  logic                 cmp_gt_u_i,
    output logic                 update_valid_o,
    output logic                 update_taken_o,
    output logic                 mispredict_o,
    output branch_pkg::addr_t    update_target_o,
    output branch_pkg::addr_t    update_pc_o
);
    import branch_pkg::*;

    logic  taken_d;
    addr_t seq_pc;
    addr_t target_d;
    logic  mispred_d;

    logic  res_valid_q;
    logic  res_taken_q;
    logic  res_mispred_q;
    addr_t res_target_q;
    addr_t res_pc_q;
    logic  report;

    // Per-kind taken decision from the registered flags
    always_comb begin
        case (cmp_kind_i)
            `BRA_BEQ:  taken_d = cmp_eq_i;
            `BRA_BNE:  taken_d = !cmp_eq_i;
            `BRA_BLT:  taken_d = !cmp_gt_s_i && !cmp_eq_i;
            `BRA_BGE:  taken_d = cmp_gt_s_i || cmp_eq_i;
            `BRA_BLTU: taken_d = !cmp_gt_u_i && !cmp_eq_i;
            `BRA_BGEU: taken_d = cmp_gt_u_i || cmp_eq_i;
            default:   taken_d = 1'b0; // Filtered out at decode
        endcase
    end

    // Fall-through depends on the instruction length
    assign seq_pc    = cmp_pc_i + (cmp_compressed_i ? 32'd2 : 32'd4);
    assign target_d  = taken_d ? (cmp_pc_i + cmp_imm_i) : seq_pc;
    assign mispred_d = (taken_d != cmp_pred_i);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            res_valid_q <= 1'b0;
        end else if (!stall_i) begin
            res_valid_q <= cmp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            res_taken_q   <= taken_d;
            res_mispred_q <= mispred_d;
            res_target_q  <= target_d;
            res_pc_q      <= cmp_pc_i;
        end
    end

    // A held entry is shown only once the stall lifts
    assign report = res_valid_q && !stall_i;

    assign update_valid_o  = report;
    assign update_taken_o  = report ? res_taken_q : 1'b0;
    assign mispredict_o    = report ? res_mispred_q : 1'b0;
    assign update_target_o = report ? res_target_q : {`XLEN{1'b0}};
    assign update_pc_o     = report ? res_pc_q : {`XLEN{1'b0}};

endmodule

`default_nettype wire

/* rtl/branch_unit_top.sv */
`default_nettype none

module branch_unit_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               valid_i,
    input  logic               stall_i,
    input  branch_pkg::instr_t instr_i,
    input  branch_pkg::addr_t  pc_i,
    input  branch_pkg::word_t  rs1_val_i,
    input  branch_pkg::word_t  rs2_val_i,
    input  logic               pred_taken_i,
    output logic               update_valid_o,
    output logic               update_taken_o,
    output logic               mispredict_o,
    output branch_pkg::addr_t  update_target_o,
    output branch_pkg::addr_t  update_pc_o
);
    import branch_pkg::*;

    // Decode to compare
    logic     dec_valid;
    br_kind_t dec_kind;
    addr_t    dec_pc;
    addr_t    dec_imm;
    logic     dec_compressed;
    logic     dec_pred;
    word_t    dec_op_a;
    word_t    dec_op_b;

    // Compare to resolve
    logic     cmp_valid;
    br_kind_t cmp_kind;
    addr_t    cmp_pc;
    addr_t    cmp_imm;
    logic     cmp_compressed;
    logic     cmp_pred;
    logic     cmp_eq;
    logic     cmp_gt_s;
    logic     cmp_gt_u;

    branch_decode u_decode (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .valid_i          (valid_i),
        .instr_i          (instr_i),
        .pc_i             (pc_i),
        .rs1_val_i        (rs1_val_i),
        .rs2_val_i        (rs2_val_i),
        .pred_taken_i     (pred_taken_i),
        .dec_valid_o      (dec_valid),
        .dec_kind_o       (dec_kind),
        .dec_pc_o         (dec_pc),
        .dec_imm_o        (dec_imm),
        .dec_compressed_o (dec_compressed),
        .dec_pred_o       (dec_pred),
        .dec_op_a_o       (dec_op_a),
        .dec_op_b_o       (dec_op_b)
    );

    branch_compare u_compare (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .dec_valid_i      (dec_valid),
        .dec_kind_i       (dec_kind),
        .dec_pc_i         (dec_pc),
        .dec_imm_i        (dec_imm),
        .dec_compressed_i (dec_compressed),
        .dec_pred_i       (dec_pred),
        .dec_op_a_i       (dec_op_a),
        .dec_op_b_i       (dec_op_b),
        .cmp_valid_o      (cmp_valid),
        .cmp_kind_o       (cmp_kind),
        .cmp_pc_o         (cmp_pc),
        .cmp_imm_o        (cmp_imm),
        .cmp_compressed_o (cmp_compressed),
        .cmp_pred_o       (cmp_pred),
        .cmp_eq_o         (cmp_eq),
        .cmp_gt_s_o       (cmp_gt_s),
        .cmp_gt_u_o       (cmp_gt_u)
    );

    branch_resolve u_resolve (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .cmp_valid_i      (cmp_valid),
        .cmp_kind_i       (cmp_kind),
        .cmp_pc_i         (cmp_pc),
        .cmp_imm_i        (cmp_imm),
        .cmp_compressed_i (cmp_compressed),
        .cmp_pred_i       (cmp_pred),
        .cmp_eq_i         (cmp_eq),
        .cmp_gt_s_i       (cmp_gt_s),
        .cmp_gt_u_i       (cmp_gt_u),
        .update_valid_o   (update_valid_o),
        .update_taken_o   (update_taken_o),
        .mispredict_o     (mispredict_o),
        .update_target_o  (update_target_o),
        .update_pc_o      (update_pc_o)
    );

endmodule

`default_nettype wire

/* dv/branch_unit_tb.sv */
`default_nettype none

`include "branch_params.svh"

module branch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import branch_pkg::*;

    logic   clk_i;
    logic   rst_i;
    logic   valid_i;
    logic   stall_i;
    instr_t instr_i;
    addr_t  pc_i;
    word_t  rs1_val_i;
    word_t  rs2_val_i;
    logic   pred_taken_i;
    logic   update_valid_o;
    logic   update_taken_o;
    logic   mispredict_o;
    addr_t  update_target_o;
    addr_t  update_pc_o;

    // Expected results, oldest first
    logic  exp_taken_q[$];
    logic  exp_mis_q[$];
    addr_t exp_target_q[$];
    addr_t exp_pc_q[$];

    int edges = 0;
    int drive_edge = 0;
    int report_edge = 0;

    // Last branch of the trace, replayed for the latency check
    instr_t last_instr;
    addr_t  last_pc;
    word_t  last_rs1;
    word_t  last_rs2;
    logic   last_pred;
    logic   last_taken;
    addr_t  last_target;
    logic   last_mis;

    branch_unit_top dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .stall_i         (stall_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_val_i       (rs1_val_i),
        .rs2_val_i       (rs2_val_i),
        .pred_taken_i    (pred_taken_i),
        .update_valid_o  (update_valid_o),
        .update_taken_o  (update_taken_o),
        .mispredict_o    (mispredict_o),
        .update_target_o (update_target_o),
        .update_pc_o     (update_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        edges = edges + 1;
    end

    task automatic abort_run(input string what);
        $display("%s at %0t", what, $time);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic random_stall(input logic use_stall);
        return use_stall && (($urandom % 4) == 0);
    endfunction

    // Holds the word on the inputs until an unstalled edge takes it
    task automatic drive_word(input instr_t instr, input addr_t pc, input word_t rs1,
                              input word_t rs2, input logic pred, input logic is_branch,
                              input logic taken, input addr_t target, input logic mis,
                              input logic use_stall);
        int waited;
        waited = 0;
        @(negedge clk_i);
        valid_i      = 1'b1;
        instr_i      = instr;
        pc_i         = pc;
        rs1_val_i    = rs1;
        rs2_val_i    = rs2;
        pred_taken_i = pred;
        stall_i      = random_stall(use_stall);
        while (stall_i) begin
            @(negedge clk_i);
            stall_i = random_stall(use_stall);
            waited++;
            if (waited > 100) abort_run("stall never released while driving");
        end
        drive_edge = edges;
        if (is_branch) begin
            exp_taken_q.push_back(taken);
            exp_target_q.push_back(target);
            exp_mis_q.push_back(mis);
            exp_pc_q.push_back(pc);
        end
    endtask

    task automatic drain(input logic use_stall);
        int waited;
        waited = 0;
        while (exp_pc_q.size() != 0) begin
            @(negedge clk_i);
            valid_i = 1'b0;
            stall_i = random_stall(use_stall);
            waited++;
            if (waited > 200) abort_run("timeout waiting for pending updates");
        end
    endtask

    task automatic run_trace();
        int     fd;
        int     n;
        int     f_pred;
        int     f_mis;
        reg [8*160-1:0] line;
        reg [63:0] f_tok;
        instr_t f_instr;
        addr_t  f_pc;
        addr_t  f_target;
        word_t  f_rs1;
        word_t  f_rs2;
        logic   is_branch;
        fd = $fopen("dv/branch_trace.txt", "r");
        if (fd == 0) abort_run("cannot open dv/branch_trace.txt");
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %d %s %h %d", f_instr, f_pc, f_rs1, f_rs2,
                        f_pred, f_tok, f_target, f_mis);
            if (n == 8) begin // Comment and blank lines parse short
                is_branch = (f_tok != 64'("none"));
                drive_word(f_instr, f_pc, f_rs1, f_rs2, f_pred[0], is_branch,
                           f_tok == 64'("1"), f_target, f_mis[0], 1'b1);
                if (is_branch) begin
                    last_instr  = f_instr;
                    last_pc     = f_pc;
                    last_rs1    = f_rs1;
                    last_rs2    = f_rs2;
                    last_pred   = f_pred[0];
                    last_taken  = (f_tok == 64'("1"));
                    last_target = f_target;
                    last_mis    = f_mis[0];
                end
            end
        end
        $fclose(fd);
    endtask

    // Samples just before the rising edge, after the falling-edge drive
    initial begin
        forever begin
            @(negedge clk_i);
            #4;
            if (!update_valid_o) begin
                check_value("idle update_taken_o", 32'(update_taken_o), 32'd0);
                check_value("idle mispredict_o", 32'(mispredict_o), 32'd0);
                check_value("idle update_target_o", update_target_o, 32'd0);
                check_value("idle update_pc_o", update_pc_o, 32'd0);
            end else if (!rst_i) begin
                abort_run("update reported during reset");
            end else if (exp_pc_q.size() == 0) begin
                abort_run("update reported with no branch pending");
            end else begin
                check_value("update_pc_o", update_pc_o, exp_pc_q.pop_front());
                check_value("update_taken_o", 32'(update_taken_o),
                            32'(exp_taken_q.pop_front()));
                check_value("update_target_o", update_target_o, exp_target_q.pop_front());
                check_value("mispredict_o", 32'(mispredict_o), 32'(exp_mis_q.pop_front()));
                report_edge = edges;
            end
        end
    end

    initial begin
        void'($urandom(32'h5f2d_4d01));
        rst_i        = 1'b0;
        valid_i      = 1'b1; // BEQ strobed all through reset
        stall_i      = 1'b0;
        instr_i      = 32'h0020_8863;
        pc_i         = 32'h0000_0900;
        rs1_val_i    = '0;
        rs2_val_i    = '0;
        pred_taken_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_i   = 1'b1;
        valid_i = 1'b0;
        repeat (3) @(negedge clk_i); // Quiet outputs right after reset

        run_trace();
        drain(1'b1);

        // Lone branch with the stall held off
        drive_word(last_instr, last_pc, last_rs1, last_rs2, last_pred, 1'b1,
                   last_taken, last_target, last_mis, 1'b0);
        drain(1'b0);
        check_value("latency in edges", report_edge - drive_edge, 32'd3);

        repeat (2) @(negedge clk_i);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/branch_pkg.sv
rtl/branch_decode.sv
rtl/branch_compare.sv
rtl/branch_resolve.sv
rtl/branch_unit_top.sv
dv/branch_unit_tb.sv

/* Makefile */
# Verilator flow for the branch unit

VERILATOR ?= verilator
TOP       ?= branch_unit_tb
RTL_TOP   ?= branch_unit_top
SRCS      ?= -f sources.f
VFLAGS    ?= --timing -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) $(SRCS) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): sources.f rtl/*.sv rtl/*.svh dv/*.sv
	$(VERILATOR) --binary $(VFLAGS) $(SRCS) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/branch_trace.txt */
# instr    pc       rs1      rs2      pred taken target   mispredict
# taken is 1 or 0 for a branch, none for a word that must give no update
00208863 00001000 00000005 00000005 1 1 00001010 0
fe208ce3 00001100 00000005 00000006 1 0 00001104 1
00100093 00008000 00000000 00000000 0 none 00000000 0
fe208ce3 00001200 0000000a 0000000a 0 1 000011f8 1
00209863 00002000 00000001 00000002 1 1 00002010 0
fe209ce3 00002100 00000009 00000009 0 0 00002104 0
0020a863 00008100 00000001 00000001 1 none 00000000 0
0020c863 00003000 ffffffff 00000001 0 1 00003010 1
fe20cce3 00003100 00000001 ffffffff 0 0 00003104 0
fe20cce3 00003200 fffffffb fffffffb 1 0 00003204 1
0020c863 00003300 fffffff8 ffffffff 1 1 00003310 0
0020b863 00008200 00000001 00000002 1 none 00000000 0
0020d863 00004000 00000007 00000007 1 1 00004010 0
fe20dce3 00004100 fffffffe 00000003 0 0 00004104 0
fe20dce3 00004200 00000003 80000000 0 1 000041f8 1
0020e863 00005000 00000001 ffffffff 1 1 00005010 0
fe20ece3 00005100 ffffffff 00000001 1 0 00005104 1
0020e863 00005200 80000000 ffffffff 0 1 00005210 1
00000001 00008300 00000000 00000000 0 none 00000000 0
0020f863 00006000 80000000 7fffffff 0 1 00006010 1
0020f863 00006100 00000002 fffffffe 0 0 00006104 0
fe20fce3 00006200 00000009 00000009 1 1 000061f8 0
0000a001 00008400 00000000 00000000 0 none 00000000 0
0000c401 00007000 00000000 00000005 1 1 00007008 0
0000dc75 00007100 00000005 00000005 1 0 00007102 1
0000dc75 00007200 00000000 00000000 0 1 000071fc 1
0000c002 00008500 00000000 00000000 1 none 00000000 0
0000e401 00007300 00000003 00000000 1 1 00007308 0
0000fc75 00007400 00000000 00000007 0 0 00007402 0
0000fc75 00007500 ffffffff 00000000 1 1 000074fc 0
